//--- source/phold_params.svh
`ifndef PHOLD_PARAMS_SVH
`define PHOLD_PARAMS_SVH

// timestamp width
`define PHOLD_TIME_WID 16

// logical process id width
`define PHOLD_LP_WID 8

// processing cores served by the scheduler
`define PHOLD_NUM_CORE 4

// event queue entries
`define PHOLD_Q_DEPTH 16

// num_init_events width, up to 16 initial events
`define PHOLD_INIT_WID 5

`endif

//--- source/phold_pkg.sv
`default_nettype none

`include "phold_params.svh"

package phold_pkg;

   // cancel set means anti-message
   // cancel set with lp and ts zero is the null message
   typedef struct packed {
      logic                       cancel;
      logic [`PHOLD_LP_WID-1:0]   lp;
      logic [`PHOLD_TIME_WID-1:0] ts;
   } event_msg_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_INIT,
      ST_READY,
      ST_RUNNING,
      ST_FINISHED
   } run_state_t;

endpackage

`default_nettype wire

//--- source/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "phold_params.svh"

module rr_arbiter #(
   parameter int NUM_REQ = `PHOLD_NUM_CORE,
   parameter int ID_WID  = $clog2(NUM_REQ)
) (
   input  wire                clk,
   input  wire                rst_n,
   input  wire  [NUM_REQ-1:0] req,
   input  wire                advance,
   output logic [NUM_REQ-1:0] gnt,
   output logic [ID_WID-1:0]  gnt_id,
   output logic               gnt_vld
);

   // index of the most recent winner
   logic [ID_WID-1:0] last_id;

   // search starts one past the last winner and wraps around
   always_comb begin
      int idx;
      gnt     = '0;
      gnt_id  = '0;
      gnt_vld = 1'b0;
      for (int i = 1; i <= NUM_REQ; i++) begin
         idx = (int'(last_id) + i) % NUM_REQ;
         if (!gnt_vld && req[idx]) begin
            gnt_vld  = 1'b1;
            gnt_id   = ID_WID'(idx);
            gnt[idx] = 1'b1;
         end
      end
   end

   // pointer only moves when the grant is used
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last_id <= ID_WID'(NUM_REQ - 1);
      end else if (advance && gnt_vld) begin
         last_id <= gnt_id;
      end
   end

endmodule

`default_nettype wire

//--- source/event_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "phold_params.svh"

module event_queue #(
   parameter int DEPTH = `PHOLD_Q_DEPTH
) (
   input  wire                   clk,
   input  wire                   rst_n,
   input  wire                   enq,
   input  wire                   deq,
   input  wire  phold_pkg::event_msg_t in_msg,
   output phold_pkg::event_msg_t head,
   output logic                  full,
   output logic                  empty
);
   import phold_pkg::*;

   localparam int CNT_WID = $clog2(DEPTH + 1);
   localparam int KEY_WID = `PHOLD_TIME_WID + 1;

   event_msg_t           q [DEPTH];
   logic [CNT_WID-1:0]   count;
   logic [KEY_WID-1:0]   in_key;
   logic [DEPTH-1:0]     place;
   logic                 do_enq;
   logic                 do_deq;

   // inverted cancel bit puts anti-messages first at equal timestamps
   assign in_key = {in_msg.ts, ~in_msg.cancel};

   // slots at or above the insertion point, thermometer coded
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         place[i] = (i >= int'(count)) || ({q[i].ts, ~q[i].cancel} > in_key);
      end
   end

   assign full   = (count == CNT_WID'(DEPTH));
   assign empty  = (count == '0);
   assign head   = q[0];
   assign do_enq = enq && !full;
   assign do_deq = deq && !enq && !empty;

   // sorted insert shifts the larger entries up by one
   always_ff @(posedge clk) begin
      if (do_enq) begin
         if (place[0]) begin
            q[0] <= in_msg;
         end
         for (int i = 1; i < DEPTH; i++) begin
            if (place[i]) begin
               q[i] <= place[i-1] ? q[i-1] : in_msg;
            end
         end
      end else if (do_deq) begin
         for (int i = 0; i < DEPTH - 1; i++) begin
            q[i] <= q[i+1];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (do_enq) begin
         count <= count + 1'b1;
      end else if (do_deq) begin
         count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- source/run_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "phold_params.svh"

module run_control (
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire                          start,
   input  wire  [`PHOLD_INIT_WID-1:0]   num_init_events,
   input  wire  [`PHOLD_LP_WID-1:0]     lp_mask,
   input  wire  [`PHOLD_TIME_WID-1:0]   gvt,
   input  wire  [`PHOLD_TIME_WID-1:0]   sim_end,
   input  wire                          q_full,
   input  wire                          any_busy,
   input  wire                          q_idle,
   output phold_pkg::run_state_t        state,
   output phold_pkg::event_msg_t        init_msg,
   output logic                         init_enq,
   output logic                         block_dispatch,
   output logic                         rtn_vld,
   output logic                         cleanup
);
   import phold_pkg::*;

   run_state_t                  state_nxt;
   logic [`PHOLD_INIT_WID-1:0]  init_cnt;
   logic                        init_done;
   logic                        active;
   logic                        past_end;
   logic                        rtn_nxt;

   assign init_done      = (init_cnt == num_init_events);
   assign active         = (state == ST_INIT) || (state == ST_READY) || (state == ST_RUNNING);
   assign past_end       = (state == ST_RUNNING) && (gvt > sim_end);
   assign block_dispatch = past_end;

   // one init event per two cycles, q_idle low on the gap cycle
   assign init_enq = (state == ST_INIT) && q_idle && !init_done && !q_full;

   assign init_msg.cancel = 1'b0;
   assign init_msg.lp     = lp_mask & `PHOLD_LP_WID'(init_cnt);
   assign init_msg.ts     = '0;

   always_comb begin
      state_nxt = state;
      rtn_nxt   = rtn_vld;
      case (state)
         ST_IDLE: begin
            if (start) begin
               state_nxt = ST_INIT;
               rtn_nxt   = 1'b0;
            end
         end
         ST_INIT: if (init_done) state_nxt = ST_READY;
         ST_READY: state_nxt = ST_RUNNING;
         ST_RUNNING: begin
            // wait for the cores to drain before finishing
            if (past_end) begin
               rtn_nxt = 1'b1;
               if (!any_busy) state_nxt = ST_FINISHED;
            end
         end
         default: state_nxt = ST_IDLE;
      endcase
      // overflow aborts the run
      if (active && q_full) begin
         state_nxt = ST_FINISHED;
         rtn_nxt   = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= ST_IDLE;
         rtn_vld  <= 1'b0;
         cleanup  <= 1'b0;
         init_cnt <= '0;
      end else begin
         state    <= state_nxt;
         rtn_vld  <= rtn_nxt;
         cleanup  <= (state_nxt == ST_FINISHED);
         if (state != ST_INIT) begin
            init_cnt <= '0;
         end else if (init_enq) begin
            init_cnt <= init_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/gvt_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "phold_params.svh"

module gvt_tracker #(
   parameter int NUM_CORE = `PHOLD_NUM_CORE
) (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire                         running,
   input  wire  [NUM_CORE-1:0]         dispatch,
   input  wire  [`PHOLD_TIME_WID-1:0]  dispatch_ts,
   input  wire  [NUM_CORE-1:0]         core_done,
   input  wire  [`PHOLD_TIME_WID-1:0]  head_ts,
   input  wire                         q_empty,
   output logic [NUM_CORE-1:0]         busy,
   output logic                        any_busy,
   output logic [`PHOLD_TIME_WID-1:0]  gvt
);

   // timestamp of the event each core is working on
   logic [`PHOLD_TIME_WID-1:0] core_ts [NUM_CORE];
   logic [`PHOLD_TIME_WID-1:0] min_ts;
   logic                       min_vld;

   assign any_busy = |busy;

   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_CORE; i++) begin
         if (dispatch[i]) core_ts[i] <= dispatch_ts;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= '0;
      end else begin
         busy <= (busy & ~core_done) | dispatch;
      end
   end

   // minimum over queue head and in-flight events
   always_comb begin
      min_ts  = head_ts;
      min_vld = !q_empty;
      for (int i = 0; i < NUM_CORE; i++) begin
         if (busy[i] && (!min_vld || core_ts[i] < min_ts)) begin
            min_ts  = core_ts[i];
            min_vld = 1'b1;
         end
      end
   end

   // holds when nothing is pending anywhere
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt <= '0;
      end else if (running && min_vld) begin
         gvt <= min_ts;
      end
   end

endmodule

`default_nettype wire

//--- source/event_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "phold_params.svh"

module event_scheduler (
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire                          start,
   input  wire  [`PHOLD_TIME_WID-1:0]   sim_end,
   input  wire  [`PHOLD_INIT_WID-1:0]   num_init_events,
   input  wire  [`PHOLD_LP_WID-1:0]     lp_mask,
   output logic [`PHOLD_TIME_WID-1:0]   gvt,
   output logic                         rtn_vld,
   output logic                         cleanup,
   output logic [31:0]                  total_events,
   output logic [31:0]                  total_cycles,
   input  wire  [`PHOLD_NUM_CORE-1:0]   core_ready,
   output logic [`PHOLD_NUM_CORE-1:0]   core_evt_vld,
   output phold_pkg::event_msg_t        core_evt_msg,
   input  wire  [`PHOLD_NUM_CORE-1:0]   core_out_vld,
   input  wire  phold_pkg::event_msg_t  core_out_msg [`PHOLD_NUM_CORE],
   output logic [`PHOLD_NUM_CORE-1:0]   core_out_ack,
   input  wire  [`PHOLD_NUM_CORE-1:0]   core_done
);
   import phold_pkg::*;

   localparam int NUM_CORE = `PHOLD_NUM_CORE;
   localparam int ID_WID   = $clog2(NUM_CORE);
   localparam event_msg_t NULL_MSG = '{cancel: 1'b1, lp: '0, ts: '0};

   run_state_t            state;
   event_msg_t            init_msg;
   event_msg_t            head;
   event_msg_t            enq_msg;
   event_msg_t            rcv_msg;
   logic                  init_enq;
   logic                  block_dispatch;
   logic                  q_full;
   logic                  q_empty;
   logic [NUM_CORE-1:0]   busy;
   logic                  any_busy;
   logic [NUM_CORE-1:0]   disp_gnt;
   logic                  disp_vld;
   logic [NUM_CORE-1:0]   rcv_gnt;
   logic [ID_WID-1:0]     rcv_id;
   logic                  rcv_vld;
   logic                  queue_busy;
   logic                  running;
   logic                  run_start;
   logic                  take;
   logic                  q_enq;
   logic                  deq_op;
   logic                  drain;
   logic                  past_end;

   assign running   = (state == ST_RUNNING);
   assign run_start = start && (state == ST_IDLE);
   assign rcv_msg   = core_out_msg[rcv_id];
   assign past_end  = head.ts > sim_end;

   // one queue operation, then one idle cycle; taking from a core wins
   assign take    = running && !queue_busy && rcv_vld && !q_full;
   assign q_enq   = init_enq || (take && (rcv_msg != NULL_MSG));
   assign enq_msg = (state == ST_INIT) ? init_msg : rcv_msg;
   assign deq_op  = running && !queue_busy && !take && !q_empty && disp_vld &&
                    !block_dispatch && !past_end;
   // leftovers of a finished run are discarded while idle
   assign drain   = (state == ST_IDLE) && !queue_busy && !q_empty;

   assign core_out_ack = take ? rcv_gnt : '0;

   run_control run_control_inst (
      .clk             (clk),
      .rst_n           (rst_n),
      .start           (start),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .gvt             (gvt),
      .sim_end         (sim_end),
      .q_full          (q_full),
      .any_busy        (any_busy),
      .q_idle          (!queue_busy),
      .state           (state),
      .init_msg        (init_msg),
      .init_enq        (init_enq),
      .block_dispatch  (block_dispatch),
      .rtn_vld         (rtn_vld),
      .cleanup         (cleanup)
   );

   event_queue event_queue_inst (
      .clk    (clk),
      .rst_n  (rst_n),
      .enq    (q_enq),
      .deq    (deq_op || drain),
      .in_msg (enq_msg),
      .head   (head),
      .full   (q_full),
      .empty  (q_empty)
   );

   // gvt also follows the queue in ready so running starts from a fresh value
   gvt_tracker gvt_tracker_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .running     (running || (state == ST_READY)),
      .dispatch    (deq_op ? disp_gnt : '0),
      .dispatch_ts (head.ts),
      .core_done   (core_done),
      .head_ts     (head.ts),
      .q_empty     (q_empty),
      .busy        (busy),
      .any_busy    (any_busy),
      .gvt         (gvt)
   );

   rr_arbiter dispatch_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (core_ready & ~busy),
      .advance (deq_op),
      .gnt     (disp_gnt),
      .gnt_id  (),
      .gnt_vld (disp_vld)
   );

   rr_arbiter receive_arb (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (core_out_vld),
      .advance (take),
      .gnt     (rcv_gnt),
      .gnt_id  (rcv_id),
      .gnt_vld (rcv_vld)
   );

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         queue_busy   <= 1'b0;
         core_evt_vld <= '0;
      end else begin
         queue_busy   <= init_enq || take || deq_op || drain;
         core_evt_vld <= deq_op ? disp_gnt : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (deq_op) core_evt_msg <= head;
   end

   // run statistics
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         total_events <= '0;
         total_cycles <= '0;
      end else if (run_start) begin
         total_events <= '0;
         total_cycles <= '0;
      end else begin
         if (deq_op) total_events <= total_events + 32'd1;
         if (running) total_cycles <= total_cycles + 32'd1;
      end
   end

endmodule

`default_nettype wire

//--- tb/event_scheduler_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "phold_params.svh"

module event_scheduler_assert (
   input wire                         clk,
   input wire                         rst_n,
   input wire [`PHOLD_NUM_CORE-1:0]   core_evt_vld,
   input wire [`PHOLD_NUM_CORE-1:0]   core_out_ack,
   input wire                         cleanup,
   input wire                         rtn_vld
);

   // set by cleanup, kept while rtn_vld stays high
   logic cleaned;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cleaned <= 1'b0;
      end else begin
         cleaned <= cleanup || (rtn_vld && cleaned);
      end
   end

   evt_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(core_evt_vld))
      else $error("core_evt_vld has more than one bit set");

   ack_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(core_out_ack))
      else $error("core_out_ack has more than one bit set");

   cleanup_single: assert property (@(posedge clk) disable iff (!rst_n) cleanup |=> !cleanup)
      else $error("cleanup high for two cycles");

   rtn_held: assert property (@(posedge clk) disable iff (!rst_n) $fell(rtn_vld) |-> cleaned)
      else $error("rtn_vld dropped before cleanup");

endmodule

bind event_scheduler event_scheduler_assert event_scheduler_assert_inst (
   .clk          (clk),
   .rst_n        (rst_n),
   .core_evt_vld (core_evt_vld),
   .core_out_ack (core_out_ack),
   .cleanup      (cleanup),
   .rtn_vld      (rtn_vld)
);

`default_nettype wire

//--- tb/tb_event_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "phold_params.svh"

module tb_event_scheduler;
   import phold_pkg::*;

   localparam int NC         = `PHOLD_NUM_CORE;
   localparam int MAX_CYCLES = 6000;
   localparam event_msg_t NULL_MSG = '{cancel: 1'b1, lp: '0, ts: '0};

   logic                        clk = 1'b0;
   logic                        rst_n;
   logic                        start;
   logic [`PHOLD_TIME_WID-1:0]  sim_end;
   logic [`PHOLD_INIT_WID-1:0]  num_init_events;
   logic [`PHOLD_LP_WID-1:0]    lp_mask;
   logic [`PHOLD_TIME_WID-1:0]  gvt;
   logic                        rtn_vld;
   logic                        cleanup;
   logic [31:0]                 total_events;
   logic [31:0]                 total_cycles;
   logic [NC-1:0]               core_ready;
   logic [NC-1:0]               core_evt_vld;
   event_msg_t                  core_evt_msg;
   logic [NC-1:0]               core_out_vld;
   event_msg_t                  core_out_msg [NC];
   logic [NC-1:0]               core_out_ack;
   logic [NC-1:0]               core_done;

   // core model behavior selected by core_mode
   // 0 hold, 1 chain ts+5, 2 ordering table, 3 null then normal
   int          core_mode;
   logic [NC-1:0] ack_q;
   logic [NC-1:0] holding;
   event_msg_t  held [NC];
   int          wait_cnt [NC];
   int          offer_idx [NC];
   event_msg_t  delivered [$];
   int          null_acks;
   int          cleanup_cnt;
   int          late_evts;
   int          errors;
   int          tests_run;
   int          tests_failed;
   int          cycle_cnt;
   int          start_cyc;
   int          cleanup_cyc;
   int          seed = 32'hddab;

   event_scheduler event_scheduler_inst (
      .clk             (clk),
      .rst_n           (rst_n),
      .start           (start),
      .sim_end         (sim_end),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .gvt             (gvt),
      .rtn_vld         (rtn_vld),
      .cleanup         (cleanup),
      .total_events    (total_events),
      .total_cycles    (total_cycles),
      .core_ready      (core_ready),
      .core_evt_vld    (core_evt_vld),
      .core_evt_msg    (core_evt_msg),
      .core_out_vld    (core_out_vld),
      .core_out_msg    (core_out_msg),
      .core_out_ack    (core_out_ack),
      .core_done       (core_done)
   );

   always #10 clk = ~clk;

   function automatic int offer_total(event_msg_t m);
      if (core_mode == 0) return 0;
      if (core_mode == 1) return 1;
      if (m.ts != '0) return 0;
      return (core_mode == 2) ? 1 : 2;
   endfunction

   function automatic event_msg_t offer_msg(event_msg_t m, int k);
      event_msg_t o;
      o.cancel = 1'b0;
      o.lp     = m.lp;
      o.ts     = m.ts + 16'd5;
      if (core_mode == 2) begin
         // lp 2 sends an anti-message with the same timestamp as lp 1
         case (m.lp[1:0])
            2'd0: o.ts = 16'd10;
            2'd1: o.ts = 16'd7;
            2'd2: begin
               o.ts     = 16'd7;
               o.cancel = 1'b1;
            end
            default: o.ts = 16'd12;
         endcase
      end else if (core_mode == 3 && k == 0) begin
         o = NULL_MSG;
      end
      return o;
   endfunction

   always @(posedge clk) ack_q <= core_out_ack;

   // core models drive their outputs on the falling edge
   always @(negedge clk) begin
      core_done = '0;
      for (int i = 0; i < NC; i++) begin
         if (!rst_n) begin
            core_ready[i]   = 1'b1;
            core_out_vld[i] = 1'b0;
            holding[i]      = 1'b0;
         end else begin
            if (core_out_vld[i] && ack_q[i]) begin
               if (core_out_msg[i] == NULL_MSG) null_acks++;
               offer_idx[i]++;
               if (offer_idx[i] < offer_total(held[i])) begin
                  core_out_msg[i] = offer_msg(held[i], offer_idx[i]);
               end else begin
                  core_out_vld[i] = 1'b0;
               end
            end
            if (core_evt_vld[i]) begin
               if (holding[i]) begin
                  errors++;
                  $display("core %0d got a second event before its core_done", i);
               end
               held[i]       = core_evt_msg;
               holding[i]    = 1'b1;
               core_ready[i] = 1'b0;
               delivered.push_back(core_evt_msg);
               wait_cnt[i]   = ((core_mode == 2) ? 20 : 4) + ($unsigned($random(seed)) % 8);
               offer_idx[i]  = 0;
               if (offer_total(core_evt_msg) > 0) begin
                  core_out_vld[i] = 1'b1;
                  core_out_msg[i] = offer_msg(core_evt_msg, 0);
               end
            end else if (holding[i] && core_mode != 0) begin
               if (wait_cnt[i] > 0) begin
                  wait_cnt[i]--;
               end else if (core_out_vld == '0) begin
                  // done only once every pending offer was taken
                  core_done[i]  = 1'b1;
                  holding[i]    = 1'b0;
                  core_ready[i] = 1'b1;
               end
            end
         end
      end
   end

   always @(negedge clk) begin
      if (rst_n) begin
         if (cleanup) begin
            if (cleanup_cnt == 0) cleanup_cyc = cycle_cnt;
            cleanup_cnt++;
         end
         if ((|core_evt_vld) && rtn_vld) late_evts++;
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
         $display("sim failed");
         $finish;
      end
   end

   task automatic check(string name, logic [31:0] got, logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic report(string name, int errs_before);
      tests_run++;
      if (errors != errs_before) tests_failed++;
      $display("test %s: %s", name, (errors == errs_before) ? "ok" : "FAILED");
   endtask

   task automatic clear_counts();
      delivered.delete();
      null_acks   = 0;
      cleanup_cnt = 0;
      late_evts   = 0;
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst_n = 1'b0;
      start = 1'b0;
      repeat (16) @(negedge clk);
      clear_counts();
      rst_n = 1'b1;
   endtask

   task automatic start_run(int n, logic [7:0] mask, logic [15:0] end_ts, int mode);
      core_mode       = mode;
      num_init_events = n[`PHOLD_INIT_WID-1:0];
      lp_mask         = mask;
      sim_end         = end_ts;
      start           = 1'b1;
      start_cyc       = cycle_cnt;
      @(negedge clk);
      start = 1'b0;
   endtask

   task automatic wait_cleanup();
      while (cleanup_cnt == 0) @(negedge clk);
      repeat (10) @(negedge clk);
   endtask

   task automatic reset_values();
      int e;
      e = errors;
      apply_reset();
      repeat (5) @(negedge clk);
      check("gvt", 32'(gvt), 0);
      check("rtn_vld", 32'(rtn_vld), 0);
      check("cleanup", 32'(cleanup), 0);
      check("core_evt_vld", 32'(core_evt_vld), 0);
      check("core_out_ack", 32'(core_out_ack), 0);
      check("total_events", total_events, 0);
      check("total_cycles", total_cycles, 0);
      report("reset", e);
   endtask

   task automatic initial_insertion();
      int e;
      logic [3:0] lp_seen;
      e = errors;
      lp_seen = '0;
      apply_reset();
      start_run(4, 8'd3, 16'hffff, 0);
      while (delivered.size() < 4) @(posedge clk);
      repeat (20) @(posedge clk);
      check("deliveries", delivered.size(), 4);
      foreach (delivered[k]) begin
         check("core_evt_msg.ts", 32'(delivered[k].ts), 0);
         check("core_evt_msg.lp", 32'(delivered[k].lp & 8'hfc), 0);
         lp_seen[delivered[k].lp[1:0]] = 1'b1;
      end
      check("lp set", 32'(lp_seen), 32'hf);
      report("init", e);
   endtask

   task automatic event_ordering();
      int e;
      int exp_ts [7] = '{0, 0, 0, 0, 7, 7, 10};
      int exp_cn [7] = '{0, 0, 0, 0, 1, 0, 0};
      e = errors;
      apply_reset();
      start_run(4, 8'd3, 16'd11, 2);
      wait_cleanup();
      check("deliveries", delivered.size(), 7);
      for (int k = 0; k < 7 && k < delivered.size(); k++) begin
         check("core_evt_msg.ts", 32'(delivered[k].ts), exp_ts[k]);
         check("core_evt_msg.cancel", 32'(delivered[k].cancel), exp_cn[k]);
      end
      report("ordering", e);
   endtask

   task automatic null_filtering();
      int e;
      e = errors;
      apply_reset();
      start_run(1, 8'd3, 16'd2, 3);
      wait_cleanup();
      check("deliveries", delivered.size(), 1);
      check("null acks", null_acks, 1);
      check("total_events", total_events, 1);
      if (delivered.size() > 0) check("core_evt_msg.cancel", 32'(delivered[0].cancel), 0);
      report("null", e);
   endtask

   task automatic run_completion();
      int e;
      int over;
      e = errors;
      over = 0;
      apply_reset();
      start_run(4, 8'd3, 16'd20, 1);
      wait_cleanup();
      // four chains of timestamps 0, 5, 10, 15 and 20
      check("deliveries", delivered.size(), 20);
      foreach (delivered[k]) if (delivered[k].ts > 16'd20) over++;
      check("deliveries above sim_end", over, 0);
      check("total_events", total_events, delivered.size());
      // init takes two cycles per event and ready one more, running ends at cleanup
      check("total_cycles", total_cycles, cleanup_cyc - start_cyc - 2 * 4 - 2);
      check("cleanup pulses", cleanup_cnt, 1);
      check("deliveries after rtn_vld", late_evts, 0);
      check("rtn_vld", 32'(rtn_vld), 1);
      check("gvt above sim_end", 32'(gvt > 16'd20), 1);
      report("completion", e);
   endtask

   task automatic queue_overflow();
      int e;
      e = errors;
      // restarts right after the completion run while rtn_vld is still high
      clear_counts();
      start_run(16, 8'd15, 16'hffff, 0);
      wait_cleanup();
      check("deliveries", delivered.size(), 0);
      check("rtn_vld", 32'(rtn_vld), 1);
      check("cleanup pulses", cleanup_cnt, 1);
      check("total_events", total_events, 0);
      check("total_cycles", total_cycles, 0);
      report("overflow", e);
   endtask

   initial begin
      rst_n           = 1'b0;
      start           = 1'b0;
      sim_end         = '0;
      num_init_events = '0;
      lp_mask         = '0;
      core_ready      = '1;
      core_out_vld    = '0;
      core_done       = '0;
      core_mode       = 0;
      for (int i = 0; i < NC; i++) core_out_msg[i] = '0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      cycle_cnt    = 0;
      start_cyc    = 0;
      cleanup_cyc  = 0;
      reset_values();
      initial_insertion();
      event_ordering();
      null_filtering();
      run_completion();
      queue_overflow();
      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- event_scheduler.f
+incdir+source
source/phold_pkg.sv
source/rr_arbiter.sv
source/event_queue.sv
source/run_control.sv
source/gvt_tracker.sv
source/event_scheduler.sv
tb/event_scheduler_assert.sv
tb/tb_event_scheduler.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f event_scheduler.f \
		--top-module tb_event_scheduler -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
